//--- common/fdc_pkg.sv
`default_nettype none

package fdc_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [6:0]  track_t;
	typedef logic [19:0] img_addr_t;
	typedef logic [10:0] sec_len_t;

	// host visible register map
	typedef enum logic [1:0] {
		REG_CMD_STATUS = 2'd0,
		REG_TRACK      = 2'd1,
		REG_SECTOR     = 2'd2,
		REG_DATA       = 2'd3
	} reg_sel_e;

	typedef enum logic [3:0] {
		IDLE,
		SEEK_WAIT,
		SETUP,
		BYTE_GAP,
		DRQ_WAIT,
		SETTLE,
		ABORT,
		DONE
	} seq_state_e;

	// one-cycle strobes from the host bus
	typedef struct packed {
		logic  cmd_wr;
		logic  track_wr;
		logic  sector_wr;
		logic  data_wr;
		logic  data_rd_done;
		logic  status_rd_done;
		byte_t wdata;
	} host_req_t;

	typedef struct packed {
		byte_t      sectors_per_track;
		logic [1:0] size_code;
		img_addr_t  sector_base;
	} geom_t;

	typedef struct packed {
		logic busy;
		logic drq;
		logic intrq;
		logic head_loaded;
		logic seek_err;
		logic lost_data;
		logic type1_mode;
		logic track0;
	} fdc_flags_t;

	// delays in ce ticks
	localparam logic [9:0]  SEEK_DELAY     = 10'd1023;
	localparam logic [11:0] SETTLE_TICKS   = 12'd4000;
	localparam logic [3:0]  BYTE_GAP_TICKS = 4'd15;
	localparam logic [12:0] WATCHDOG_TICKS = 13'd4096;
	localparam logic [15:0] INDEX_PERIOD   = 16'd35000;
	localparam logic [15:0] INDEX_WIDTH    = 16'd100;

endpackage

`default_nettype wire

//--- hw/host_port.sv
`timescale 1ns/1ps
`default_nettype none

module host_port import fdc_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       ce,
	input  logic       io_en,
	input  logic       rd,
	input  logic       wr,
	input  reg_sel_e   addr,
	input  byte_t      din,
	input  fdc_flags_t flags,
	input  logic       ready,
	input  logic       index,
	input  byte_t      track_reg,
	input  byte_t      sector_reg,
	input  byte_t      data_reg,
	input  byte_t      read_byte,
	output host_req_t  req,
	output byte_t      dout
);

	logic     rde;
	logic     wre;
	logic     old_rd;
	logic     old_wr;
	reg_sel_e cur_addr;
	byte_t    status;

	assign rde = rd & io_en;
	assign wre = wr & io_en;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_rd <= 1'b0;
			old_wr <= 1'b0;
			cur_addr <= REG_CMD_STATUS;
			req <= '0;
		end else if (ce) begin
			old_rd <= rde;
			old_wr <= wre;
			{req.cmd_wr, req.track_wr, req.sector_wr, req.data_wr} <= 4'b0000;
			{req.data_rd_done, req.status_rd_done} <= 2'b00;
			// reads finish on the trailing edge, so keep the select
			if (!old_rd && rde)
				cur_addr <= addr;
			if (!old_wr && wre) begin
				req.wdata <= din;
				case (addr)
					REG_CMD_STATUS: req.cmd_wr <= 1'b1;
					REG_TRACK:      req.track_wr <= 1'b1;
					REG_SECTOR:     req.sector_wr <= 1'b1;
					REG_DATA:       req.data_wr <= 1'b1;
				endcase
			end
			if (old_rd && !rde) begin
				req.data_rd_done <= (cur_addr == REG_DATA);
				req.status_rd_done <= (cur_addr == REG_CMD_STATUS);
			end
		end
	end

	always_comb begin
		if (flags.type1_mode)
			status = {~ready, 1'b1, flags.head_loaded, flags.seek_err | ~ready,
				1'b0, flags.track0, index, flags.busy};
		else
			status = {~ready, 1'b1, 1'b0, flags.seek_err | ~ready,
				1'b0, flags.lost_data, flags.drq, flags.busy};
		dout = status;
		case (addr)
			REG_TRACK:  dout = track_reg;
			REG_SECTOR: dout = sector_reg;
			// live byte while drq, last latched byte otherwise
			REG_DATA:   dout = flags.drq ? read_byte : data_reg;
			default:    dout = status;
		endcase
	end

	// at most one host strobe per cycle, reads included
	assert property (@(posedge clk_sys) disable iff (rst)
		$onehot0({req.cmd_wr, req.track_wr, req.sector_wr, req.data_wr,
			req.data_rd_done, req.status_rd_done}));

endmodule

`default_nettype wire

//--- hw/disk_geometry.sv
`timescale 1ns/1ps
`default_nettype none

module disk_geometry import fdc_pkg::*; (
	input  logic [2:0] size_code,
	input  track_t     track,
	input  logic       side,
	input  byte_t      sector,
	output geom_t      geom
);

	byte_t      spt;
	logic [1:0] wd_code;
	sec_len_t   sec_len;
	byte_t      ltrack;
	img_addr_t  sec_idx;

	// both sides interleaved per cylinder
	assign ltrack = {track, side};

	always_comb begin
		case (size_code)
			3'd0: begin
				spt = 8'd26;
				wd_code = 2'd0;
				sec_len = 11'd128;
			end
			3'd1: begin
				spt = 8'd16;
				wd_code = 2'd1;
				sec_len = 11'd256;
			end
			3'd3: begin
				spt = 8'd5;
				wd_code = 2'd3;
				sec_len = 11'd1024;
			end
			3'd4: begin
				spt = 8'd10;
				wd_code = 2'd2;
				sec_len = 11'd512;
			end
			default: begin
				spt = 8'd9;
				wd_code = 2'd2;
				sec_len = 11'd512;
			end
		endcase
		// sectors are numbered from 1
		sec_idx = img_addr_t'(ltrack) * img_addr_t'(spt) + img_addr_t'(sector) - img_addr_t'(1);
		geom.sectors_per_track = spt;
		geom.size_code = wd_code;
		geom.sector_base = sec_idx * img_addr_t'(sec_len);
	end

endmodule

`default_nettype wire

//--- hw/drive_timers.sv
`timescale 1ns/1ps
`default_nettype none

module drive_timers import fdc_pkg::*; (
	input  logic clk_sys,
	input  logic rst,
	input  logic ce,
	input  logic ready,
	input  logic watchdog_arm,
	output logic index,
	output logic bark
);

	logic [15:0] index_cnt;
	logic [12:0] wd_cnt;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			index_cnt <= '0;
			index <= 1'b0;
			wd_cnt <= '0;
		end else if (ce) begin
			// one revolution per period while the drive spins
			if (!ready)
				index_cnt <= '0;
			else if (index_cnt == '0)
				index_cnt <= INDEX_PERIOD;
			else
				index_cnt <= index_cnt - 1'b1;
			index <= (index_cnt < INDEX_WIDTH);
			if (watchdog_arm)
				wd_cnt <= WATCHDOG_TICKS;
			else if (wd_cnt != '0)
				wd_cnt <= wd_cnt - 1'b1;
		end
	end

	assign bark = (wd_cnt == '0) && !watchdog_arm;

endmodule

`default_nettype wire

//--- fdc/fdc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_sequencer import fdc_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       ce,
	input  logic       ready,
	input  logic       side,
	input  host_req_t  req,
	input  geom_t      geom,
	input  logic       bark,
	input  byte_t      buff_din,
	output fdc_flags_t flags,
	output byte_t      track_reg,
	output byte_t      sector_reg,
	output byte_t      data_reg,
	output byte_t      read_byte,
	output track_t     track,
	output logic       watchdog_arm,
	output logic       buff_read,
	output img_addr_t  buff_addr
);

	seq_state_e  state;
	track_t      disk_track;
	logic        step_dir;
	logic        busy;
	logic        drq;
	logic        intrq;
	logic        head_loaded;
	logic        seek_err;
	logic        lost_data;
	logic        type1_mode;
	logic        rd_sector;
	logic        multisector;
	sec_len_t    byte_cnt;
	sec_len_t    byte_idx;
	byte_t       id_field [6];
	byte_t       id_sec;
	logic [9:0]  seek_timer;
	logic [11:0] settle_cnt;
	logic [3:0]  gap_cnt;
	logic [3:0]  cmd;
	logic        cmd_accept;
	logic        step_out;
	track_t      next_track;
	sec_len_t    sec_len;
	byte_t       id_byte;

	assign cmd = req.wdata[7:4];
	// force interrupt is the only command taken while busy
	assign cmd_accept = req.cmd_wr && (state == IDLE || cmd == 4'hD);
	assign step_out = req.wdata[6] ? req.wdata[5] : step_dir;
	// no stepping out past track 0
	assign next_track = step_out ? ((disk_track == '0) ? '0 : disk_track - 1'b1)
		: disk_track + 1'b1;
	assign sec_len = sec_len_t'(11'd128 << geom.size_code);

	assign id_byte = (byte_idx < sec_len_t'(6)) ? id_field[byte_idx[2:0]] : '0;
	assign read_byte = rd_sector ? buff_din : id_byte;
	assign buff_addr = geom.sector_base + img_addr_t'(byte_idx);
	assign buff_read = rd_sector & drq;
	assign watchdog_arm = (state == BYTE_GAP);
	assign track = disk_track;

	assign flags = '{busy: busy, drq: drq, intrq: intrq, head_loaded: head_loaded,
		seek_err: seek_err, lost_data: lost_data, type1_mode: type1_mode,
		track0: (disk_track == '0)};

	// id field of read address
	always_ff @(posedge clk_sys) begin
		if (ce && cmd_accept && cmd == 4'hC) begin
			id_field[0] <= {1'b0, disk_track};
			id_field[1] <= {7'b0, side};
			id_field[2] <= id_sec;
			id_field[3] <= {6'b0, geom.size_code};
			id_field[4] <= '0;
			id_field[5] <= '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= IDLE;
			disk_track <= '0;
			step_dir <= 1'b0;
			{busy, drq, intrq, head_loaded} <= 4'b0000;
			{seek_err, lost_data, type1_mode} <= 3'b000;
			rd_sector <= 1'b0;
			multisector <= 1'b0;
			track_reg <= '0;
			sector_reg <= '0;
			data_reg <= '0;
			byte_cnt <= '0;
			byte_idx <= '0;
			id_sec <= 8'd1;
			seek_timer <= SEEK_DELAY;
			settle_cnt <= '0;
			gap_cnt <= '0;
		end else if (ce) begin
			if (req.status_rd_done)
				intrq <= 1'b0;

			case (state)
				IDLE: ;
				SEEK_WAIT:
					if (!ready) begin
						seek_err <= 1'b1;
						state <= DONE;
					end else begin
						seek_timer <= seek_timer - 1'b1;
						if (seek_timer == '0)
							state <= SETUP;
					end
				SETUP: begin
					byte_idx <= '0;
					gap_cnt <= BYTE_GAP_TICKS;
					if (!rd_sector) begin
						byte_cnt <= sec_len_t'(6);
						state <= BYTE_GAP;
					end else if (sector_reg == '0 || sector_reg > geom.sectors_per_track) begin
						seek_err <= 1'b1;
						state <= DONE;
					end else begin
						byte_cnt <= sec_len;
						state <= BYTE_GAP;
					end
				end
				BYTE_GAP: begin
					gap_cnt <= gap_cnt - 1'b1;
					if (gap_cnt == '0) begin
						drq <= 1'b1;
						state <= DRQ_WAIT;
					end
				end
				DRQ_WAIT:
					if (bark || req.data_rd_done) begin
						drq <= 1'b0;
						data_reg <= read_byte;
						if (bark)
							lost_data <= 1'b1;
						if (byte_cnt == sec_len_t'(1)) begin
							if (rd_sector && multisector) begin
								sector_reg <= sector_reg + 1'b1;
								seek_timer <= SEEK_DELAY;
								state <= SEEK_WAIT;
							end else begin
								state <= DONE;
							end
						end else begin
							byte_idx <= byte_idx + 1'b1;
							byte_cnt <= byte_cnt - 1'b1;
							gap_cnt <= BYTE_GAP_TICKS;
							state <= BYTE_GAP;
						end
					end
				SETTLE:
					if (settle_cnt == '0)
						state <= DONE;
					else
						settle_cnt <= settle_cnt - 1'b1;
				ABORT: begin
					drq <= 1'b0;
					seek_err <= 1'b0;
					lost_data <= 1'b0;
					state <= DONE;
				end
				DONE: begin
					busy <= 1'b0;
					drq <= 1'b0;
					intrq <= 1'b1;
					rd_sector <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase

			if (cmd_accept) begin
				// E and F are not supported and leave intrq alone
				if (cmd < 4'hE)
					intrq <= 1'b0;
				case (cmd)
					4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
						busy <= 1'b1;
						type1_mode <= 1'b1;
						head_loaded <= req.wdata[3];
						settle_cnt <= SETTLE_TICKS - 12'd1;
						state <= SETTLE;
						if (cmd == 4'h0) begin
							disk_track <= '0;
							track_reg <= '0;
						end else if (cmd == 4'h1) begin
							disk_track <= data_reg[6:0];
							track_reg <= data_reg;
						end else begin
							if (req.wdata[6])
								step_dir <= req.wdata[5];
							disk_track <= next_track;
							if (req.wdata[4])
								track_reg <= {1'b0, next_track};
						end
					end
					4'h8, 4'h9, 4'hA, 4'hB: begin
						busy <= 1'b1;
						type1_mode <= 1'b0;
						seek_err <= 1'b0;
						lost_data <= 1'b0;
						// the disk is always write protected
						if (req.wdata[5]) begin
							state <= DONE;
						end else begin
							rd_sector <= 1'b1;
							multisector <= req.wdata[4];
							seek_timer <= SEEK_DELAY;
							state <= SEEK_WAIT;
						end
					end
					4'hC: begin
						busy <= 1'b1;
						type1_mode <= 1'b0;
						seek_err <= 1'b0;
						lost_data <= 1'b0;
						rd_sector <= 1'b0;
						multisector <= 1'b0;
						seek_timer <= SEEK_DELAY;
						state <= SEEK_WAIT;
						if (id_sec >= geom.sectors_per_track)
							id_sec <= 8'd1;
						else
							id_sec <= id_sec + 1'b1;
					end
					4'hD: begin
						type1_mode <= 1'b1;
						if (state != IDLE) begin
							state <= ABORT;
						end else begin
							{seek_err, lost_data} <= 2'b00;
						end
					end
					default: ;
				endcase
			end

			if (req.track_wr && !busy)
				track_reg <= req.wdata;
			if (req.sector_wr && !busy)
				sector_reg <= req.wdata;
			if (req.data_wr)
				data_reg <= req.wdata;
		end
	end

	assert property (@(posedge clk_sys) disable iff (rst) drq |-> busy);
	assert property (@(posedge clk_sys) disable iff (rst) buff_read |-> busy);

endmodule

`default_nettype wire

//--- hw/fdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_top import fdc_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       ce,
	input  logic       io_en,
	input  logic       rd,
	input  logic       wr,
	input  logic       ready,
	input  logic       side,
	input  reg_sel_e   addr,
	input  byte_t      din,
	input  logic [2:0] size_code,
	input  byte_t      buff_din,
	output byte_t      dout,
	output logic       drq,
	output logic       intrq,
	output logic       busy,
	output logic       buff_read,
	output img_addr_t  buff_addr
);

	host_req_t  req;
	fdc_flags_t flags;
	geom_t      geom;
	byte_t      track_reg;
	byte_t      sector_reg;
	byte_t      data_reg;
	byte_t      read_byte;
	track_t     track;
	logic       watchdog_arm;
	logic       index;
	logic       bark;

	host_port u_host_port (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.ce         (ce),
		.io_en      (io_en),
		.rd         (rd),
		.wr         (wr),
		.addr       (addr),
		.din        (din),
		.flags      (flags),
		.ready      (ready),
		.index      (index),
		.track_reg  (track_reg),
		.sector_reg (sector_reg),
		.data_reg   (data_reg),
		.read_byte  (read_byte),
		.req        (req),
		.dout       (dout)
	);

	fdc_sequencer u_sequencer (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.ce           (ce),
		.ready        (ready),
		.side         (side),
		.req          (req),
		.geom         (geom),
		.bark         (bark),
		.buff_din     (buff_din),
		.flags        (flags),
		.track_reg    (track_reg),
		.sector_reg   (sector_reg),
		.data_reg     (data_reg),
		.read_byte    (read_byte),
		.track        (track),
		.watchdog_arm (watchdog_arm),
		.buff_read    (buff_read),
		.buff_addr    (buff_addr)
	);

	disk_geometry u_geometry (
		.size_code (size_code),
		.track     (track),
		.side      (side),
		.sector    (sector_reg),
		.geom      (geom)
	);

	drive_timers u_timers (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.ce           (ce),
		.ready        (ready),
		.watchdog_arm (watchdog_arm),
		.index        (index),
		.bark         (bark)
	);

	assign drq = flags.drq;
	assign intrq = flags.intrq;
	assign busy = flags.busy;

endmodule

`default_nettype wire

//--- test/fdc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_tb import fdc_pkg::*; ();

	localparam int WAIT_LIMIT = 2 * WATCHDOG_TICKS;
	// the tests need roughly 26k cycles
	localparam int CYCLE_LIMIT = 60000;

	logic       clk_sys;
	logic       rst;
	logic       ce;
	logic       io_en;
	logic       rd;
	logic       wr;
	logic       ready;
	logic       side;
	reg_sel_e   addr;
	byte_t      din;
	logic [2:0] size_code;
	byte_t      buff_din;
	byte_t      dout;
	logic       drq;
	logic       intrq;
	logic       busy;
	logic       buff_read;
	img_addr_t  buff_addr;

	int    errors = 0;
	int    prop_errors = 0;
	int    cycles;
	byte_t lfsr;

	fdc_top uut (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ce        (ce),
		.io_en     (io_en),
		.rd        (rd),
		.wr        (wr),
		.ready     (ready),
		.side      (side),
		.addr      (addr),
		.din       (din),
		.size_code (size_code),
		.buff_din  (buff_din),
		.dout      (dout),
		.drq       (drq),
		.intrq     (intrq),
		.busy      (busy),
		.buff_read (buff_read),
		.buff_addr (buff_addr)
	);

	function automatic byte_t image_byte(input img_addr_t a);
		logic [31:0] v;
		v = 32'(a) * 32'd7 + 32'd86;
		return v[7:0];
	endfunction

	// right-shifting galois form with taps x^8+x^6+x^5+x^4+1
	function automatic byte_t lfsr_next(input byte_t s);
		if (s[0])
			return (s >> 1) ^ 8'hB8;
		return s >> 1;
	endfunction

	// image buffer answers in the same cycle
	assign buff_din = image_byte(buff_addr);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycles = cycles + 1;
		end
		$display("timeout: no result after %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	// a command's busy phase always ends in intrq
	assert property (@(posedge clk_sys) disable iff (rst) !(busy && intrq))
	else begin
		prop_errors = prop_errors + 1;
		$display("busy and intrq are high in the same cycle");
	end

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check_eq(input string name, input int exp, input int act);
		assert (exp == act)
		else begin
			errors = errors + 1;
			$display("Fail %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic bus_write(input reg_sel_e a, input byte_t d);
		@(posedge clk_sys);
		addr <= a;
		din <= d;
		io_en <= 1'b1;
		wr <= 1'b1;
		repeat (2) @(posedge clk_sys);
		io_en <= 1'b0;
		wr <= 1'b0;
	endtask

	task automatic bus_read(input reg_sel_e a, output byte_t d);
		@(posedge clk_sys);
		addr <= a;
		io_en <= 1'b1;
		rd <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		d = dout;
		@(posedge clk_sys);
		io_en <= 1'b0;
		rd <= 1'b0;
	endtask

	task automatic wait_drq(input logic level);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (drq !== level && n < WAIT_LIMIT);
		assert (drq === level)
		else begin
			errors = errors + 1;
			$display("drq did not reach %0b within %0d cycles", level, WAIT_LIMIT);
		end
	endtask

	task automatic wait_idle(output int n);
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (busy !== 1'b0 && n < WAIT_LIMIT);
		assert (busy === 1'b0)
		else begin
			errors = errors + 1;
			$display("busy still high after %0d cycles", n);
		end
	endtask

	task automatic read_address(input int exp_sec, input int trk, input int sd);
		byte_t val;
		byte_t exp_id [6];
		int n;
		// WD size code 2 for 512-byte sectors
		exp_id = '{byte_t'(trk), byte_t'(sd), byte_t'(exp_sec), 8'd2, 8'd0, 8'd0};
		bus_write(REG_CMD_STATUS, 8'hC0);
		for (int j = 0; j < 6; j++) begin
			wait_drq(1'b1);
			bus_read(REG_DATA, val);
			check_eq($sformatf("read_address byte %0d", j), exp_id[j], val);
			wait_drq(1'b0);
		end
		wait_idle(n);
		check_eq("read_address intrq", 1, intrq);
	endtask

	initial begin
		int target;
		int sd;
		int sec;
		int n;
		byte_t val;
		byte_t st;
		img_addr_t exp_addr;

		lfsr = 8'd86;
		rst <= 1'b1;
		ce <= 1'b1;
		io_en <= 1'b0;
		rd <= 1'b0;
		wr <= 1'b0;
		ready <= 1'b1;
		side <= 1'b0;
		addr <= REG_CMD_STATUS;
		din <= '0;
		size_code <= 3'd2;
		repeat (8) @(posedge clk_sys);
		rst <= 1'b0;

		@(negedge clk_sys);
		check_eq("reset busy", 0, busy);
		check_eq("reset drq", 0, drq);
		check_eq("reset intrq", 0, intrq);
		check_eq("reset buff_read", 0, buff_read);
		bus_read(REG_TRACK, val);
		check_eq("reset track", 0, val);

		// seek target goes through the data register
		take_bits(7, target);
		target = target % 80;
		bus_write(REG_DATA, byte_t'(target));
		bus_write(REG_CMD_STATUS, 8'h10);
		@(negedge clk_sys);
		check_eq("seek busy", 1, busy);
		wait_idle(n);
		check_eq("seek busy fall cycle", int'(SETTLE_TICKS) + 2, n + 1);
		check_eq("seek intrq", 1, intrq);
		bus_read(REG_TRACK, val);
		check_eq("seek track", target, val);
		bus_read(REG_CMD_STATUS, st);
		// index bit masked
		check_eq("seek status", (target == 0) ? 8'h44 : 8'h40, st & 8'hFD);
		repeat (3) @(negedge clk_sys);
		check_eq("seek intrq after status", 0, intrq);

		take_bits(1, sd);
		take_bits(4, sec);
		sec = sec % 9 + 1;
		@(posedge clk_sys);
		side <= sd[0];
		bus_write(REG_SECTOR, byte_t'(sec));
		bus_write(REG_CMD_STATUS, 8'h80);
		for (int i = 0; i < 512; i++) begin
			wait_drq(1'b1);
			if (i == 0)
				check_eq("read_sector buff_read", 1, buff_read);
			exp_addr = img_addr_t'(((2 * target + sd) * 9 + sec - 1) * 512 + i);
			check_eq("read_sector buff_addr", int'(exp_addr), int'(buff_addr));
			bus_read(REG_DATA, val);
			check_eq($sformatf("read_sector byte %0d", i), image_byte(exp_addr), val);
			wait_drq(1'b0);
		end
		wait_idle(n);
		check_eq("read_sector intrq", 1, intrq);

		read_address(1, target, sd);
		read_address(2, target, sd);

		// leave a byte unread until the watchdog fires
		bus_write(REG_CMD_STATUS, 8'h80);
		wait_drq(1'b1);
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (drq === 1'b1 && n < WAIT_LIMIT);
		assert (n > int'(WATCHDOG_TICKS))
		else begin
			errors = errors + 1;
			$display("drq dropped after %0d cycles, before the watchdog ran out", n);
		end
		bus_read(REG_CMD_STATUS, st);
		check_eq("lost_data status bit", 1, st[2]);
		check_eq("lost_data busy bit", 1, st[0]);
		bus_write(REG_CMD_STATUS, 8'hD0);
		wait_idle(n);
		check_eq("force_int intrq", 1, intrq);

		// clear intrq so that only the write command can raise it
		bus_read(REG_CMD_STATUS, st);
		bus_write(REG_CMD_STATUS, 8'hA0);
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (intrq !== 1'b1 && n < WAIT_LIMIT);
		check_eq("write_protect intrq", 1, intrq);
		check_eq("write_protect busy", 0, busy);
		bus_read(REG_CMD_STATUS, st);
		check_eq("write_protect status bit", 1, st[6]);

		@(posedge clk_sys);
		ready <= 1'b0;
		bus_write(REG_CMD_STATUS, 8'h80);
		wait_idle(n);
		bus_read(REG_CMD_STATUS, st);
		check_eq("not_ready status bit", 1, st[7]);
		check_eq("not_ready seek error bit", 1, st[4]);
		// drive back up, bit 4 then shows only the latched seek error
		@(posedge clk_sys);
		ready <= 1'b1;
		bus_read(REG_CMD_STATUS, st);
		check_eq("not_ready seek error latched", 1, st[4]);
		repeat (2) @(negedge clk_sys);

		$display("errors: %0d failed checks, %0d property violations", errors, prop_errors);
		if (errors == 0 && prop_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- wd1793_fdc.f
common/fdc_pkg.sv
hw/host_port.sv
hw/disk_geometry.sv
hw/drive_timers.sv
fdc/fdc_sequencer.sv
hw/fdc_top.sv
test/fdc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator and run the fdc testbench from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fdc_tb \
	-f wd1793_fdc.f -o fdc_sim > build.log 2>&1 &&
	./obj_dir/fdc_sim > sim.log 2>&1
# the log decides the result
grep -q "^Simulation passed$" sim.log && echo "PASS" || {
	echo "FAIL, see build.log and sim.log"
	exit 1
}
